//--- dv/lsq_trace.txt
# Columns (hex): I kind size tag addr data | C tag | E tag data cause | W cycles | D dead | H/B seen
# kind 0 load 1 store; size 0 byte 1 half 2 word; cause 0 none 1 misaligned 2 access fault 3 bus error
I 1 2 01 00002000 123480c3
C 01
E 01 00000000 0
I 0 2 02 00002000 00000000
I 0 0 03 00002000 00000000
I 0 0 04 00002001 00000000
I 0 0 05 00002002 00000000
I 0 1 06 00002000 00000000
I 0 1 07 00002002 00000000
E 02 123480c3 0
E 03 ffffffc3 0
E 04 ffffff80 0
E 05 00000034 0
E 06 ffff80c3 0
E 07 00001234 0
I 0 1 08 00002001 00000000
I 1 2 09 00000ffc 11111111
I 0 2 0a 00010000 00000000
I 0 2 0b 00000002 00000000
E 08 00000000 1
E 09 00000000 2
E 0a 00000000 2
E 0b 00000000 1
I 1 2 10 00002100 cafe0001
I 0 2 11 00002200 00000000
E 11 ddff2200 0
C 10
E 10 00000000 0
H 0
I 1 2 12 00002300 5555aaaa
I 0 2 13 00002300 00000000
W 06
H 1
C 12
E 12 00000000 0
E 13 5555aaaa 0
D 1
I 0 2 14 00002400 00000000
E 14 00000000 3
D 0
I 0 2 15 00002400 00000000
E 15 dbff2400 0
I 0 2 16 00003000 00000000
I 0 2 17 00003004 00000000
I 0 2 18 00003008 00000000
I 0 2 19 0000300c 00000000
I 0 2 1a 00003010 00000000
I 0 2 1b 00003014 00000000
I 0 2 1c 00003018 00000000
I 0 2 1d 0000301c 00000000
I 0 2 1e 00003020 00000000
I 0 2 1f 00003024 00000000
B 1
E 16 cfff3000 0
E 17 cffb3004 0
E 18 cff73008 0
E 19 cff3300c 0
E 1a cfef3010 0
E 1b cfeb3014 0
E 1c cfe73018 0
E 1d cfe3301c 0
E 1e cfdf3020 0
E 1f cfdb3024 0

//--- compile.f
+incdir+design
design/lsq_pkg.sv
design/ack_timer.sv
design/mem_port_fsm.sv
design/store_buffer.sv
design/load_store_queue.sv
design/lsq_top.sv
dv/tb_clock_gen.sv
dv/lsq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the load/store unit testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
    --top-module lsq_tb -o lsq_sim && ./obj_dir/lsq_sim; } > sim.log 2>&1 \
    || echo "Test failed: build or simulation ended abnormally" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "RESULT: FAIL"; exit 1; } || { echo "RESULT: PASS"; exit 0; }

//--- dv/lsq_tb.sv
// Load/store unit testbench with trace driver, memory model, response monitor and checks
`timescale 1ns/1ps
`default_nettype none

`include "lsq_defines.svh"

module lsq_tb;

    import lsq_pkg::*;

    localparam int WAIT_LIMIT = 200;        // Cycles allowed for any single wait
    localparam int MEM_WORDS  = 16384;      // Covers the 64 KiB address space

    logic               clk;
    logic               rstn;
    mem_op_t            op;
    logic               ready;
    logic               commit_valid;
    logic [`TAG_W-1:0]  commit_tag;
    mem_req_t           mem_req;
    logic               mem_req_valid;
    logic               mem_ack;
    logic [`DATA_W-1:0] mem_rdata;
    lsq_resp_t          resp;
    logic               resp_valid;
    logic               collision;

    logic               dead_window;        // Memory never acks while set
    logic [31:0]        mem [MEM_WORDS];
    logic               issued_kind [2**`TAG_W];   // Kind of each issued tag
    lsq_resp_t          resp_q [$];
    int                 collision_cnt = 0;
    int                 stall_cnt = 0;

    tb_clock_gen i_tb_clock_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    lsq_top i_lsq_top (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .op_i            (op),
        .ready_o         (ready),
        .commit_valid_i  (commit_valid),
        .commit_tag_i    (commit_tag),
        .mem_req_o       (mem_req),
        .mem_req_valid_o (mem_req_valid),
        .mem_ack_i       (mem_ack),
        .mem_rdata_i     (mem_rdata),
        .resp_o          (resp),
        .resp_valid_o    (resp_valid),
        .collision_o     (collision)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %0t %s: actual %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    // Faulted operations must never show up on the memory port
    function automatic logic req_is_legal(input mem_req_t req);
        logic aligned;
        case (req.strb)
            4'b1111:                            aligned = req.addr[1:0] == 2'b00;
            4'b0011, 4'b1100:                   aligned = !req.addr[0];
            4'b0001, 4'b0010, 4'b0100, 4'b1000: aligned = 1'b1;
            default:                            aligned = 1'b0;
        endcase
        return aligned && req.addr >= `MEM_LO && req.addr < `MEM_HI;
    endfunction

    task automatic issue_op(input logic [31:0] kind, input logic [31:0] size,
                            input logic [31:0] tag, input logic [31:0] addr,
                            input logic [31:0] data);
        int waited;
        waited       = 0;
        issued_kind[tag[`TAG_W-1:0]] = kind[0];
        op.valid     = 1'b1;
        op.kind      = mem_kind_e'(kind[0]);
        op.size      = mem_size_e'(size[1:0]);
        op.tag       = tag[`TAG_W-1:0];
        op.addr      = addr;
        op.data      = data;
        while (!ready) begin                // Held until the queue has room
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("timeout waiting for ready_o to accept tag %h", tag));
            end
            @(negedge clk);
            waited++;
        end
        @(negedge clk);                     // Accepted on the rising edge in between
        op.valid = 1'b0;
    endtask

    task automatic send_commit(input logic [31:0] tag);
        commit_valid = 1'b1;
        commit_tag   = tag[`TAG_W-1:0];
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic expect_resp(input logic [31:0] tag, input logic [31:0] data,
                               input logic [31:0] cause);
        lsq_resp_t got;
        int        waited;
        waited = 0;
        while (resp_q.size() == 0) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("timeout waiting for the response of tag %h", tag));
            end
            @(negedge clk);
            waited++;
        end
        got = resp_q.pop_front();
        check_value("resp_o.tag", 32'(got.tag), tag);
        check_value("resp_o.kind", 32'(got.kind), 32'(issued_kind[tag[`TAG_W-1:0]]));
        check_value("resp_o.data", got.data, data);
        check_value("resp_o.cause", 32'(got.cause), cause);
    endtask

    // Memory model, four-phase slave with a random ack delay
    initial begin
        logic [15:0] word_addr;
        int          ack_delay;
        void'($urandom(32'h6dbf40ac));
        for (int i = 0; i < MEM_WORDS; i++) begin
            word_addr = 16'(i * 4);
            mem[i]    = {~word_addr, word_addr};   // Fill from the byte address
        end
        mem_ack   = 1'b0;
        mem_rdata = '0;
        ack_delay = 0;
        forever begin
            @(negedge clk);
            if (!rstn) begin
                mem_ack   = 1'b0;
                ack_delay = 0;
            end else if (mem_ack) begin
                if (!mem_req_valid) begin
                    mem_ack = 1'b0;
                end
            end else if (mem_req_valid && !dead_window) begin
                if (ack_delay == 0) begin
                    check_value("mem_req_o legal", 32'(req_is_legal(mem_req)), 32'd1);
                    ack_delay = $urandom_range(6, 1);
                end else begin
                    ack_delay--;
                    if (ack_delay == 0) begin
                        if (mem_req.write) begin
                            for (int b = 0; b < 4; b++) begin
                                if (mem_req.strb[b]) begin
                                    mem[mem_req.addr[15:2]][8*b +: 8] = mem_req.data[8*b +: 8];
                                end
                            end
                        end else begin
                            mem_rdata = mem[mem_req.addr[15:2]];
                        end
                        mem_ack = 1'b1;
                    end
                end
            end
        end
    end

    // Response and stall monitor
    always @(negedge clk) begin
        if (rstn) begin
            if (resp_valid) begin
                resp_q.push_back(resp);
            end
            if (collision) begin
                collision_cnt++;
            end
            if (!ready) begin
                stall_cnt++;
            end
        end
    end

    initial begin
        int          fd;
        int          waited;
        int          collision_mark;
        int          stall_mark;
        string       line;
        byte         cmd;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        op             = '0;
        commit_valid   = 1'b0;
        commit_tag     = '0;
        dead_window    = 1'b0;
        waited         = 0;
        collision_mark = 0;
        stall_mark     = 0;
        fd = $fopen("dv/lsq_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file dv/lsq_trace.txt");
        end
        while (!rstn) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("timeout waiting for reset release");
            end
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            cmd = line.getc(0);
            f0  = '0;
            f1  = '0;
            f2  = '0;
            f3  = '0;
            f4  = '0;
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                          f0, f1, f2, f3, f4));
            case (cmd)
                "I": issue_op(f0, f1, f2, f3, f4);
                "C": send_commit(f0);
                "E": expect_resp(f0, f1, f2);
                "W": repeat (f0) @(negedge clk);
                "D": dead_window = f0[0];
                "H": begin
                    check_value("collision_o seen", 32'(collision_cnt > collision_mark), f0);
                    collision_mark = collision_cnt;
                end
                "B": begin
                    @(negedge clk);                 // Monitor has the last push cycle
                    check_value("ready_o low seen", 32'(stall_cnt > stall_mark), f0);
                    stall_mark = stall_cnt;
                end
                default: abort_run($sformatf("unknown trace command in line: %s", line));
            endcase
        end
        $fclose(fd);
        repeat (20) @(negedge clk);             // Room for a stray response
        if (resp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run($sformatf("%0d responses arrived that the trace does not expect",
                                resp_q.size()));
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// Testbench clock of 4 ns period and active-low reset held for 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);

    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;      // 4 ns period
        end
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;              // Released on a falling edge
    end

endmodule

`default_nettype wire

//--- design/lsq_top.sv
// Load/store unit top level with queue, store buffer, memory port FSM and ack timer
`timescale 1ns/1ps
`default_nettype none

`include "lsq_defines.svh"

module lsq_top (
    input  wire                   clk_i,
    input  wire                   rstn_i,

    input  wire lsq_pkg::mem_op_t op_i,
    output logic                  ready_o,

    input  wire                   commit_valid_i,
    input  wire [`TAG_W-1:0]      commit_tag_i,

    output lsq_pkg::mem_req_t     mem_req_o,
    output logic                  mem_req_valid_o,
    input  wire                   mem_ack_i,
    input  wire [`DATA_W-1:0]     mem_rdata_i,

    output lsq_pkg::lsq_resp_t    resp_o,
    output logic                  resp_valid_o,
    output logic                  collision_o    // Load held behind a buffered store
);

    import lsq_pkg::*;

    logic               sb_push;
    lsq_entry_t         sb_entry;
    logic               sb_full;
    logic [`ADDR_W-1:0] load_addr;
    logic               disp_valid;
    lsq_entry_t         disp_entry;
    logic               disp_take;
    logic               drain_valid;
    lsq_entry_t         drain_entry;
    logic               drain_take;
    logic               timer_run;
    logic               timer_expired;

    load_store_queue i_load_store_queue (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .op_i           (op_i),
        .ready_o        (ready_o),
        .sb_push_o      (sb_push),
        .sb_entry_o     (sb_entry),
        .sb_full_i      (sb_full),
        .sb_collision_i (collision_o),
        .load_addr_o    (load_addr),
        .disp_valid_o   (disp_valid),
        .disp_entry_o   (disp_entry),
        .disp_take_i    (disp_take)
    );

    store_buffer i_store_buffer (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .push_i         (sb_push),
        .entry_i        (sb_entry),
        .full_o         (sb_full),
        .load_addr_i    (load_addr),
        .collision_o    (collision_o),
        .commit_valid_i (commit_valid_i),
        .commit_tag_i   (commit_tag_i),
        .drain_valid_o  (drain_valid),
        .drain_entry_o  (drain_entry),
        .drain_take_i   (drain_take)
    );

    mem_port_fsm i_mem_port_fsm (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .sb_valid_i      (drain_valid),
        .sb_entry_i      (drain_entry),
        .lsq_valid_i     (disp_valid),
        .lsq_entry_i     (disp_entry),
        .sb_take_o       (drain_take),
        .lsq_take_o      (disp_take),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_ack_i       (mem_ack_i),
        .mem_rdata_i     (mem_rdata_i),
        .timer_run_o     (timer_run),
        .timer_expired_i (timer_expired),
        .resp_o          (resp_o),
        .resp_valid_o    (resp_valid_o)
    );

    ack_timer i_ack_timer (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .run_i     (timer_run),
        .expired_o (timer_expired)
    );

endmodule

`default_nettype wire

//--- design/load_store_queue.sv
// Circular operation queue with entry checks, head steering and load collision hold
`timescale 1ns/1ps
`default_nettype none

`include "lsq_defines.svh"

module load_store_queue (
    input  wire                  clk_i,
    input  wire                  rstn_i,

    input  wire lsq_pkg::mem_op_t op_i,        // From execute
    output logic                 ready_o,

    output logic                 sb_push_o,
    output lsq_pkg::lsq_entry_t  sb_entry_o,
    input  wire                  sb_full_i,
    input  wire                  sb_collision_i,
    output logic [`ADDR_W-1:0]   load_addr_o,

    output logic                 disp_valid_o,
    output lsq_pkg::lsq_entry_t  disp_entry_o,
    input  wire                  disp_take_i
);

    import lsq_pkg::*;

    localparam int PTR_W = $clog2(`LSQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    lsq_entry_t       queue_mem [`LSQ_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    logic       push;
    logic       pop;
    logic       misaligned;
    logic       out_of_window;
    lsq_entry_t new_entry;
    lsq_entry_t head_entry;
    logic       head_valid;
    logic       head_clean;
    logic       head_is_load;

    // Alignment check per access size
    always_comb begin
        case (op_i.size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = op_i.addr[0];
            SIZE_WORD: misaligned = |op_i.addr[1:0];
            default:   misaligned = 1'b1;    // Unused size code
        endcase
    end

    assign out_of_window = (op_i.addr < `MEM_LO) || (op_i.addr >= `MEM_HI);

    always_comb begin
        new_entry.op = op_i;
        if (misaligned) begin
            new_entry.cause = CAUSE_MISALIGNED;     // Wins over the window check
        end else if (out_of_window) begin
            new_entry.cause = CAUSE_ACCESS_FAULT;
        end else begin
            new_entry.cause = CAUSE_NONE;
        end
    end

    assign ready_o = count_q != CNT_W'(`LSQ_DEPTH);
    assign push    = op_i.valid && ready_o;

    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_mem[tail_q] <= new_entry;
        end
    end

    // Head decode
    assign head_entry   = queue_mem[head_q];
    assign head_valid   = count_q != '0;
    assign head_clean   = head_entry.cause == CAUSE_NONE;
    assign head_is_load = head_entry.op.kind == KIND_LOAD;

    // Clean stores move into the store buffer
    assign sb_push_o  = head_valid && head_clean && !head_is_load && !sb_full_i;
    assign sb_entry_o = head_entry;

    // Faulted entries never wait, clean loads wait out a collision
    assign disp_valid_o = head_valid && (!head_clean || (head_is_load && !sb_collision_i));
    assign disp_entry_o = head_entry;

    // All ones lies outside the window, so it never matches a buffered store
    assign load_addr_o = (head_valid && head_clean && head_is_load) ? head_entry.op.addr : '1;

    assign pop = sb_push_o || disp_take_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_take_needs_head: assert property (@(posedge clk_i) disable iff (!rstn_i)
        disp_take_i |-> disp_valid_o)
        else $error("dispatch taken without a valid queue head");

endmodule

`default_nettype wire

//--- design/store_buffer.sv
// Store buffer FIFO with commit-gated drain and word address collision search
`timescale 1ns/1ps
`default_nettype none

`include "lsq_defines.svh"

module store_buffer (
    input  wire                     clk_i,
    input  wire                     rstn_i,

    input  wire                     push_i,
    input  wire lsq_pkg::lsq_entry_t entry_i,
    output logic                    full_o,

    input  wire [`ADDR_W-1:0]       load_addr_i,
    output logic                    collision_o,

    input  wire                     commit_valid_i,
    input  wire [`TAG_W-1:0]        commit_tag_i,

    output logic                    drain_valid_o,
    output lsq_pkg::lsq_entry_t     drain_entry_o,
    input  wire                     drain_take_i
);

    import lsq_pkg::*;

    localparam int PTR_W = $clog2(`SB_DEPTH);

    lsq_entry_t          sb_mem [`SB_DEPTH];
    logic [`SB_DEPTH-1:0] valid_q;
    logic [`SB_DEPTH-1:0] committed_q;
    logic [PTR_W-1:0]    head_q;
    logic [PTR_W-1:0]    tail_q;

    assign full_o        = valid_q[tail_q];      // Tail slot taken means every slot is
    assign drain_valid_o = valid_q[head_q] && committed_q[head_q];
    assign drain_entry_o = sb_mem[head_q];

    // Word match against every live store
    always_comb begin
        collision_o = 1'b0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (valid_q[i] && sb_mem[i].op.addr[`ADDR_W-1:2] == load_addr_i[`ADDR_W-1:2]) begin
                collision_o = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            sb_mem[tail_q] <= entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q     <= '0;
            committed_q <= '0;
            head_q      <= '0;
            tail_q      <= '0;
        end else begin
            for (int i = 0; i < `SB_DEPTH; i++) begin
                if (commit_valid_i && valid_q[i] && sb_mem[i].op.tag == commit_tag_i) begin
                    committed_q[i] <= 1'b1;
                end
            end
            if (push_i) begin
                valid_q[tail_q]     <= 1'b1;
                // Commit may arrive in the very cycle of the push
                committed_q[tail_q] <= commit_valid_i && entry_i.op.tag == commit_tag_i;
                tail_q              <= tail_q + 1'b1;
            end
            if (drain_take_i) begin
                valid_q[head_q]     <= 1'b0;
                committed_q[head_q] <= 1'b0;
                head_q              <= head_q + 1'b1;
            end
        end
    end

    a_take_needs_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        drain_take_i |-> drain_valid_o)
        else $error("store drained without a committed head entry");

endmodule

`default_nettype wire

//--- design/mem_port_fsm.sv
// Four-phase req/ack FSM toward data memory with dispatch arbitration and response build
`timescale 1ns/1ps
`default_nettype none

`include "lsq_defines.svh"

module mem_port_fsm (
    input  wire                      clk_i,
    input  wire                      rstn_i,

    input  wire                      sb_valid_i,
    input  wire lsq_pkg::lsq_entry_t sb_entry_i,
    input  wire                      lsq_valid_i,
    input  wire lsq_pkg::lsq_entry_t lsq_entry_i,
    output logic                     sb_take_o,
    output logic                     lsq_take_o,

    output lsq_pkg::mem_req_t        mem_req_o,
    output logic                     mem_req_valid_o,
    input  wire                      mem_ack_i,
    input  wire [`DATA_W-1:0]        mem_rdata_i,

    output logic                     timer_run_o,
    input  wire                      timer_expired_i,

    output lsq_pkg::lsq_resp_t       resp_o,
    output logic                     resp_valid_o
);

    import lsq_pkg::*;

    localparam int STRB_W = `DATA_W / 8;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_HI,     // req high, waiting for ack
        ST_WAIT_LO,     // req low, waiting for ack release
        ST_RESPOND
    } state_e;

    state_e             state_q;
    state_e             state_d;
    lsq_entry_t         cur_q;
    cause_e             cause_q;
    logic [`DATA_W-1:0] rdata_q;

    // Lane select and sign extension of load data
    function automatic logic [`DATA_W-1:0] extend_load(input lsq_entry_t e,
                                                       input logic [`DATA_W-1:0] raw);
        logic [`DATA_W-1:0] shifted;
        shifted = raw >> {e.op.addr[1:0], 3'b000};
        case (e.op.size)
            SIZE_BYTE: return {{(`DATA_W-8){shifted[7]}}, shifted[7:0]};
            SIZE_HALF: return {{(`DATA_W-16){shifted[15]}}, shifted[15:0]};
            default:   return shifted;
        endcase
    endfunction

    // Drainable store first, then the queue head
    always_comb begin
        state_d     = state_q;
        sb_take_o   = 1'b0;
        lsq_take_o  = 1'b0;
        timer_run_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (sb_valid_i) begin
                    sb_take_o = 1'b1;
                    state_d   = ST_WAIT_HI;
                end else if (lsq_valid_i) begin
                    lsq_take_o = 1'b1;
                    if (lsq_entry_i.cause == CAUSE_NONE) begin
                        state_d = ST_WAIT_HI;
                    end else begin
                        state_d = ST_RESPOND;   // Checked fault, no memory access
                    end
                end
            end
            ST_WAIT_HI: begin
                timer_run_o = 1'b1;
                if (mem_ack_i) begin
                    state_d = ST_WAIT_LO;
                end else if (timer_expired_i) begin
                    state_d = ST_RESPOND;       // Ack already seen low here
                end
            end
            ST_WAIT_LO: begin
                if (!mem_ack_i) begin
                    state_d = ST_RESPOND;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sb_take_o) begin
            cur_q   <= sb_entry_i;
            cause_q <= sb_entry_i.cause;
        end else if (lsq_take_o) begin
            cur_q   <= lsq_entry_i;
            cause_q <= lsq_entry_i.cause;
        end
        if (state_q == ST_WAIT_HI) begin
            if (mem_ack_i) begin
                rdata_q <= extend_load(cur_q, mem_rdata_i);   // rdata valid with ack
            end else if (timer_expired_i) begin
                cause_q <= CAUSE_BUS_ERROR;
            end
        end
    end

    // Request held stable from the latched entry
    always_comb begin
        mem_req_o.write = cur_q.op.kind == KIND_STORE;
        mem_req_o.addr  = cur_q.op.addr;
        case (cur_q.op.size)
            SIZE_BYTE: begin
                mem_req_o.data = {(`DATA_W/8){cur_q.op.data[7:0]}};
                mem_req_o.strb = STRB_W'(1) << cur_q.op.addr[1:0];
            end
            SIZE_HALF: begin
                mem_req_o.data = {(`DATA_W/16){cur_q.op.data[15:0]}};
                mem_req_o.strb = STRB_W'(3) << cur_q.op.addr[1:0];
            end
            default: begin
                mem_req_o.data = cur_q.op.data;
                mem_req_o.strb = '1;
            end
        endcase
    end

    assign mem_req_valid_o = state_q == ST_WAIT_HI;

    assign resp_valid_o = state_q == ST_RESPOND;
    assign resp_o.tag   = cur_q.op.tag;
    assign resp_o.kind  = cur_q.op.kind;
    assign resp_o.cause = cause_q;
    assign resp_o.data  = (cur_q.op.kind == KIND_LOAD && cause_q == CAUSE_NONE) ? rdata_q : '0;

    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(mem_ack_i) |-> mem_req_valid_o)
        else $error("memory ack raised without a pending request");

endmodule

`default_nettype wire

//--- design/ack_timer.sv
// Saturating counter of cycles spent waiting for ack, with expiry flag
`timescale 1ns/1ps
`default_nettype none

`include "lsq_defines.svh"

module ack_timer (
    input  wire  clk_i,
    input  wire  rstn_i,
    input  wire  run_i,         // High while the port waits for ack
    output logic expired_o
);

    localparam int CNT_W = $clog2(`ACK_TIMEOUT + 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            cnt_q <= '0;
        end else if (cnt_q != CNT_W'(`ACK_TIMEOUT)) begin
            cnt_q <= cnt_q + 1'b1;      // Holds at the limit
        end
    end

    assign expired_o = cnt_q == CNT_W'(`ACK_TIMEOUT);

endmodule

`default_nettype wire

//--- design/lsq_pkg.sv
// Package with operation, queue entry, memory request, response and cause types
`default_nettype none

`include "lsq_defines.svh"

package lsq_pkg;

    typedef enum logic {
        KIND_LOAD  = 1'b0,
        KIND_STORE = 1'b1
    } mem_kind_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

    typedef enum logic [1:0] {
        CAUSE_NONE         = 2'b00,
        CAUSE_MISALIGNED   = 2'b01,
        CAUSE_ACCESS_FAULT = 2'b10,
        CAUSE_BUS_ERROR    = 2'b11
    } cause_e;

    // Operation as handed in by execute
    typedef struct packed {
        logic               valid;
        mem_kind_e          kind;
        mem_size_e          size;
        logic [`TAG_W-1:0]  tag;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } mem_op_t;

    typedef struct packed {
        mem_op_t op;
        cause_e  cause;     // Result of the entry checks
    } lsq_entry_t;

    typedef struct packed {
        logic                 write;
        logic [`ADDR_W-1:0]   addr;
        logic [`DATA_W-1:0]   data;
        logic [`DATA_W/8-1:0] strb;
    } mem_req_t;

    // Response toward writeback
    typedef struct packed {
        logic [`TAG_W-1:0]  tag;
        mem_kind_e          kind;
        logic [`DATA_W-1:0] data;
        cause_e             cause;
    } lsq_resp_t;

endpackage

`default_nettype wire

//--- design/lsq_defines.svh
// Queue depths, data path widths, legal address window and ack timeout macros
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

`define LSQ_DEPTH   8               // Operation queue entries
`define SB_DEPTH    4               // Store buffer entries

`define ADDR_W      32
`define DATA_W      32
`define TAG_W       6

// Legal physical window, upper bound excluded
`define MEM_LO      32'h0000_1000
`define MEM_HI      32'h0001_0000

`define ACK_TIMEOUT 16              // Cycles waiting for ack before a bus error

`endif
